//--- native_pkg.sv
package native_pkg;

   // ====================
   // Default widths
   // ====================

   parameter int DEF_ADDR_W  = 8;   // Word address bits
   parameter int DEF_DATA_W  = 32;
   parameter int DEF_LEN_W   = 4;   // A burst carries len + 1 beats
   parameter int DEF_N_PORTS = 3;

   // ====================
   // Burst sequencing
   // ====================

   typedef enum logic [1:0] {
      IDLE,     // Waiting for a granted read request
      FETCH,    // First memory read in flight
      STREAM    // Returning one word per cycle
   } burst_state_t;

   // Width of a port index, never below one bit
   function automatic int idx_w(input int n);
      int w;
      if (n > 1) begin
         w = $clog2(n);
      end else begin
         w = 1;
      end
      return w;
   endfunction

endpackage

//--- native_mem.sv
`timescale 1ns/1ns

module native_mem #(
   parameter int ADDR_W = native_pkg::DEF_ADDR_W,
   parameter int DATA_W = native_pkg::DEF_DATA_W
) (
   input  logic                clk_i,

   input  logic                mem_we_i,
   input  logic [ADDR_W-1:0]   mem_waddr_i,
   input  logic [DATA_W-1:0]   mem_wdata_i,
   input  logic [DATA_W/8-1:0] mem_wstrb_i,

   input  logic                mem_re_i,
   input  logic [ADDR_W-1:0]   mem_raddr_i,
   output logic [DATA_W-1:0]   mem_rdata_o
);

   localparam int STRB_W = DATA_W / 8;
   localparam int DEPTH  = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem_q [DEPTH];

   // Byte lanes without a strobe keep their stored value
   always_ff @(posedge clk_i) begin
      if (mem_we_i) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (mem_wstrb_i[b]) begin
               mem_q[mem_waddr_i][8*b +: 8] <= mem_wdata_i[8*b +: 8];
            end
         end
      end
   end

   // Same-cycle write to the read address returns the old word
   always_ff @(posedge clk_i) begin
      if (mem_re_i) begin
         mem_rdata_o <= mem_q[mem_raddr_i];
      end
   end

endmodule

//--- burst_write_engine.sv
`timescale 1ns/1ns

module burst_write_engine #(
   parameter int ADDR_W = native_pkg::DEF_ADDR_W,
   parameter int DATA_W = native_pkg::DEF_DATA_W,
   parameter int LEN_W  = native_pkg::DEF_LEN_W
) (
   input  logic                clk_i,
   input  logic                rst_i,

   input  logic                m_wvalid_i,
   input  logic [ADDR_W-1:0]   m_waddr_i,
   input  logic [DATA_W-1:0]   m_wdata_i,
   input  logic [DATA_W/8-1:0] m_wstrb_i,
   input  logic [LEN_W-1:0]    m_wlen_i,
   output logic                m_wready_o,
   output logic                m_wlast_o,

   output logic                mem_we_o,
   output logic [ADDR_W-1:0]   mem_waddr_o,
   output logic [DATA_W-1:0]   mem_wdata_o,
   output logic [DATA_W/8-1:0] mem_wstrb_o
);

   logic              active_q;   // Set between the first and the last beat
   logic [LEN_W-1:0]  cnt_q;      // Beats already committed
   logic [ADDR_W-1:0] base_q;
   logic [LEN_W-1:0]  beat_cnt;
   logic              transfer;

   // Memory accepts a beat every cycle
   assign m_wready_o = 1'b1;

   assign transfer  = m_wvalid_i && m_wready_o;
   assign beat_cnt  = active_q ? cnt_q : '0;
   assign m_wlast_o = m_wvalid_i && (beat_cnt == m_wlen_i);

   // First beat goes straight to the master's address, later beats count up from base
   always_comb begin
      mem_we_o    = transfer;
      mem_waddr_o = active_q ? base_q + ADDR_W'(cnt_q) : m_waddr_i;
      mem_wdata_o = m_wdata_i;
      mem_wstrb_o = m_wstrb_i;
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         active_q <= 1'b0;
         cnt_q    <= '0;
      end else if (transfer) begin
         if (m_wlast_o) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
         end else begin
            active_q <= 1'b1;
            cnt_q    <= beat_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (transfer && !active_q) begin
         base_q <= m_waddr_i;   // Later request addresses are ignored
      end
   end

endmodule

//--- burst_read_engine.sv
`timescale 1ns/1ns

module burst_read_engine #(
   parameter int ADDR_W = native_pkg::DEF_ADDR_W,
   parameter int DATA_W = native_pkg::DEF_DATA_W,
   parameter int LEN_W  = native_pkg::DEF_LEN_W
) (
   input  logic              clk_i,
   input  logic              rst_i,

   input  logic              m_rvalid_i,
   input  logic [ADDR_W-1:0] m_raddr_i,
   input  logic [LEN_W-1:0]  m_rlen_i,
   output logic              m_rready_o,
   output logic [DATA_W-1:0] m_rdata_o,
   output logic              m_rlast_o,

   output logic              mem_re_o,
   output logic [ADDR_W-1:0] mem_raddr_o,
   input  logic [DATA_W-1:0] mem_rdata_i
);
   import native_pkg::*;

   burst_state_t      state_q;
   logic [ADDR_W-1:0] addr_q;   // Next word to fetch
   logic [LEN_W-1:0]  len_q;
   logic [LEN_W-1:0]  cnt_q;    // Beats already returned
   logic              beat_done;
   logic              final_beat;

   assign final_beat = (state_q == STREAM) && (cnt_q == len_q);
   assign beat_done  = (state_q == STREAM) && m_rvalid_i;

   // ====================
   // Return path
   // ====================

   always_comb begin
      m_rready_o  = (state_q == STREAM);
      m_rdata_o   = mem_rdata_i;   // Registered memory output lines up with STREAM
      m_rlast_o   = final_beat;
      mem_re_o    = (state_q == FETCH) || (beat_done && !final_beat);
      mem_raddr_o = addr_q;
   end

   // ====================
   // Sequencing
   // ====================

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (m_rvalid_i) begin
                  state_q <= FETCH;
                  cnt_q   <= '0;
               end
            end
            FETCH: begin
               state_q <= STREAM;
            end
            STREAM: begin
               if (beat_done) begin
                  if (final_beat) begin
                     state_q <= IDLE;
                  end else begin
                     cnt_q <= cnt_q + 1'b1;
                  end
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && m_rvalid_i) begin
         addr_q <= m_raddr_i;
         len_q  <= m_rlen_i;
      end else if (mem_re_o) begin
         addr_q <= addr_q + ADDR_W'(1);   // Prefetch walks one word ahead
      end
   end

endmodule

//--- native_mux.sv
`timescale 1ns/1ns

module native_mux #(
   parameter int N_PORTS = native_pkg::DEF_N_PORTS,
   parameter int ADDR_W  = native_pkg::DEF_ADDR_W,
   parameter int DATA_W  = native_pkg::DEF_DATA_W,
   parameter int LEN_W   = native_pkg::DEF_LEN_W
) (
   input  logic [N_PORTS-1:0]            s_valid_i,
   input  logic [N_PORTS*ADDR_W-1:0]     s_addr_i,
   input  logic [N_PORTS*DATA_W-1:0]     s_wdata_i,
   input  logic [N_PORTS*(DATA_W/8)-1:0] s_wstrb_i,
   input  logic [N_PORTS*LEN_W-1:0]      s_len_i,
   output logic [N_PORTS-1:0]            s_ready_o,
   output logic [N_PORTS-1:0]            s_last_o,
   output logic [DATA_W-1:0]             s_rdata_o,

   output logic                          m_wvalid_o,
   output logic [ADDR_W-1:0]             m_waddr_o,
   output logic [DATA_W-1:0]             m_wdata_o,
   output logic [DATA_W/8-1:0]           m_wstrb_o,
   output logic [LEN_W-1:0]              m_wlen_o,
   input  logic                          m_wready_i,
   input  logic                          m_wlast_i,

   output logic                          m_rvalid_o,
   output logic [ADDR_W-1:0]             m_raddr_o,
   output logic [LEN_W-1:0]              m_rlen_o,
   input  logic                          m_rready_i,
   input  logic [DATA_W-1:0]             m_rdata_i,
   input  logic                          m_rlast_i,

   input  logic                          clk_i,
   input  logic                          rst_i
);
   import native_pkg::*;

   localparam int STRB_W = DATA_W / 8;
   localparam int IDX_W  = idx_w(N_PORTS);

   logic             w_running_q;   // Write channel holds a grant
   logic [IDX_W-1:0] w_port_q;
   logic             r_running_q;   // Read channel holds a grant
   logic [IDX_W-1:0] r_port_q;

   logic             w_req_valid;
   logic [IDX_W-1:0] w_req;
   logic             r_req_valid;
   logic [IDX_W-1:0] r_req;

   logic             w_done;
   logic             r_done;

   assign w_done = m_wvalid_o && m_wready_i && m_wlast_i;
   assign r_done = m_rvalid_o && m_rready_i && m_rlast_i;

   // ====================
   // Request decode
   // ====================

   // A port finishing its burst this cycle still holds valid, so it is skipped
   always_comb begin
      w_req_valid = 1'b0;
      w_req       = '0;
      r_req_valid = 1'b0;
      r_req       = '0;
      for (int i = 0; i < N_PORTS; i++) begin
         if (s_valid_i[i]) begin
            if (|s_wstrb_i[i*STRB_W +: STRB_W]) begin
               if (!(w_done && w_port_q == IDX_W'(i))) begin
                  w_req_valid = 1'b1;
                  w_req       = IDX_W'(i);   // Later ports overwrite earlier ones
               end
            end else if (!(r_done && r_port_q == IDX_W'(i))) begin
               r_req_valid = 1'b1;
               r_req       = IDX_W'(i);
            end
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         w_running_q <= 1'b0;
         w_port_q    <= '0;
         r_running_q <= 1'b0;
         r_port_q    <= '0;
      end else begin
         if (!w_running_q || w_done) begin
            w_running_q <= w_req_valid;
            if (w_req_valid) begin
               w_port_q <= w_req;
            end
         end
         if (!r_running_q || r_done) begin
            r_running_q <= r_req_valid;
            if (r_req_valid) begin
               r_port_q <= r_req;
            end
         end
      end
   end

   // ====================
   // Channel steering
   // ====================

   always_comb begin
      m_wvalid_o = w_running_q && s_valid_i[w_port_q];
      m_waddr_o  = w_running_q ? s_addr_i[w_port_q*ADDR_W +: ADDR_W] : '0;
      m_wdata_o  = w_running_q ? s_wdata_i[w_port_q*DATA_W +: DATA_W] : '0;
      m_wstrb_o  = w_running_q ? s_wstrb_i[w_port_q*STRB_W +: STRB_W] : '0;
      m_wlen_o   = w_running_q ? s_len_i[w_port_q*LEN_W +: LEN_W] : '0;

      m_rvalid_o = r_running_q && s_valid_i[r_port_q];
      m_raddr_o  = r_running_q ? s_addr_i[r_port_q*ADDR_W +: ADDR_W] : '0;
      m_rlen_o   = r_running_q ? s_len_i[r_port_q*LEN_W +: LEN_W] : '0;
   end

   // Ready and last go back only to the bit of the granted port
   always_comb begin
      for (int i = 0; i < N_PORTS; i++) begin
         s_ready_o[i] = (w_running_q && m_wready_i && w_port_q == IDX_W'(i))
                     || (r_running_q && m_rready_i && r_port_q == IDX_W'(i));
         s_last_o[i]  = (w_running_q && m_wready_i && m_wlast_i && w_port_q == IDX_W'(i))
                     || (r_running_q && m_rready_i && m_rlast_i && r_port_q == IDX_W'(i));
      end
   end

   assign s_rdata_o = m_rdata_i;   // One read channel, so return data is shared

endmodule

//--- native_subsys_top.sv
`timescale 1ns/1ns

module native_subsys_top #(
   parameter int N_PORTS = native_pkg::DEF_N_PORTS,
   parameter int ADDR_W  = native_pkg::DEF_ADDR_W,
   parameter int DATA_W  = native_pkg::DEF_DATA_W,
   parameter int LEN_W   = native_pkg::DEF_LEN_W
) (
   input  logic                          clk_i,
   input  logic                          rst_i,

   input  logic [N_PORTS-1:0]            s_valid_i,
   input  logic [N_PORTS*ADDR_W-1:0]     s_addr_i,
   input  logic [N_PORTS*DATA_W-1:0]     s_wdata_i,
   input  logic [N_PORTS*(DATA_W/8)-1:0] s_wstrb_i,
   input  logic [N_PORTS*LEN_W-1:0]      s_len_i,
   output logic [N_PORTS-1:0]            s_ready_o,
   output logic [N_PORTS-1:0]            s_last_o,
   output logic [DATA_W-1:0]             s_rdata_o
);

   // ====================
   // Write channel
   // ====================

   logic                m_wvalid;
   logic [ADDR_W-1:0]   m_waddr;
   logic [DATA_W-1:0]   m_wdata;
   logic [DATA_W/8-1:0] m_wstrb;
   logic [LEN_W-1:0]    m_wlen;
   logic                m_wready;
   logic                m_wlast;

   // ====================
   // Read channel
   // ====================

   logic                m_rvalid;
   logic [ADDR_W-1:0]   m_raddr;
   logic [LEN_W-1:0]    m_rlen;
   logic                m_rready;
   logic [DATA_W-1:0]   m_rdata;
   logic                m_rlast;

   logic                mem_we;
   logic [ADDR_W-1:0]   mem_waddr;
   logic [DATA_W-1:0]   mem_wdata;
   logic [DATA_W/8-1:0] mem_wstrb;
   logic                mem_re;
   logic [ADDR_W-1:0]   mem_raddr;
   logic [DATA_W-1:0]   mem_rdata;

   native_mux #(
      .N_PORTS(N_PORTS),
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .LEN_W  (LEN_W)
   ) u_mux (
      .s_valid_i (s_valid_i),
      .s_addr_i  (s_addr_i),
      .s_wdata_i (s_wdata_i),
      .s_wstrb_i (s_wstrb_i),
      .s_len_i   (s_len_i),
      .s_ready_o (s_ready_o),
      .s_last_o  (s_last_o),
      .s_rdata_o (s_rdata_o),
      .m_wvalid_o(m_wvalid),
      .m_waddr_o (m_waddr),
      .m_wdata_o (m_wdata),
      .m_wstrb_o (m_wstrb),
      .m_wlen_o  (m_wlen),
      .m_wready_i(m_wready),
      .m_wlast_i (m_wlast),
      .m_rvalid_o(m_rvalid),
      .m_raddr_o (m_raddr),
      .m_rlen_o  (m_rlen),
      .m_rready_i(m_rready),
      .m_rdata_i (m_rdata),
      .m_rlast_i (m_rlast),
      .clk_i     (clk_i),
      .rst_i     (rst_i)
   );

   burst_write_engine #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W),
      .LEN_W (LEN_W)
   ) u_wr_engine (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .m_wvalid_i (m_wvalid),
      .m_waddr_i  (m_waddr),
      .m_wdata_i  (m_wdata),
      .m_wstrb_i  (m_wstrb),
      .m_wlen_i   (m_wlen),
      .m_wready_o (m_wready),
      .m_wlast_o  (m_wlast),
      .mem_we_o   (mem_we),
      .mem_waddr_o(mem_waddr),
      .mem_wdata_o(mem_wdata),
      .mem_wstrb_o(mem_wstrb)
   );

   burst_read_engine #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W),
      .LEN_W (LEN_W)
   ) u_rd_engine (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .m_rvalid_i (m_rvalid),
      .m_raddr_i  (m_raddr),
      .m_rlen_i   (m_rlen),
      .m_rready_o (m_rready),
      .m_rdata_o  (m_rdata),
      .m_rlast_o  (m_rlast),
      .mem_re_o   (mem_re),
      .mem_raddr_o(mem_raddr),
      .mem_rdata_i(mem_rdata)
   );

   native_mem #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_mem (
      .clk_i      (clk_i),
      .mem_we_i   (mem_we),
      .mem_waddr_i(mem_waddr),
      .mem_wdata_i(mem_wdata),
      .mem_wstrb_i(mem_wstrb),
      .mem_re_i   (mem_re),
      .mem_raddr_i(mem_raddr),
      .mem_rdata_o(mem_rdata)
   );

endmodule

//--- native_assertions.sv
`timescale 1ns/1ns

module native_assertions #(
   parameter int N_PORTS = native_pkg::DEF_N_PORTS,
   parameter int STRB_W  = native_pkg::DEF_DATA_W / 8,
   parameter int IDX_W   = 2
) (
   input logic                      clk_i,
   input logic                      rst_i,
   input logic [N_PORTS-1:0]        s_valid_i,
   input logic [N_PORTS*STRB_W-1:0] s_wstrb_i,
   input logic [N_PORTS-1:0]        s_ready_i,
   input logic [N_PORTS-1:0]        s_last_i,
   input logic                      m_wvalid_i,
   input logic                      w_running_i,
   input logic [IDX_W-1:0]          w_port_i,
   input logic                      r_running_i,
   input logic [IDX_W-1:0]          r_port_i
);

   int fail_cnt = 0;

   logic [N_PORTS-1:0] wr_port;   // Ports whose request carries strobes

   always_comb begin
      for (int i = 0; i < N_PORTS; i++) begin
         wr_port[i] = |s_wstrb_i[i*STRB_W +: STRB_W];
      end
   end

   // Write requests and read requests each see ready on one port at most
   a_ready_per_channel: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(s_ready_i & wr_port) && $onehot0(s_ready_i & ~wr_port))
      else begin
         fail_cnt++;
         $error("More than one ready bit on a channel");
      end

   a_last_with_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      (s_last_i & ~(s_ready_i & s_valid_i)) == '0)
      else begin
         fail_cnt++;
         $error("Last raised on a port without a transfer");
      end

   a_distinct_ports: assert property (@(posedge clk_i) disable iff (rst_i)
      (w_running_i && r_running_i) |-> (w_port_i != r_port_i))
      else begin
         fail_cnt++;
         $error("Write and read channels granted to the same port");
      end

   a_quiet_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> !m_wvalid_i)
      else begin
         fail_cnt++;
         $error("Write channel valid in the first cycle after reset");
      end

endmodule

bind native_mux native_assertions #(
   .N_PORTS(N_PORTS),
   .STRB_W (STRB_W),
   .IDX_W  (IDX_W)
) u_assert (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .s_valid_i  (s_valid_i),
   .s_wstrb_i  (s_wstrb_i),
   .s_ready_i  (s_ready_o),
   .s_last_i   (s_last_o),
   .m_wvalid_i (m_wvalid_o),
   .w_running_i(w_running_q),
   .w_port_i   (w_port_q),
   .r_running_i(r_running_q),
   .r_port_i   (r_port_q)
);

//--- tb_native_subsys.sv
`timescale 1ns/1ns

module tb_native_subsys;
   import native_pkg::*;

   localparam int N_PORTS    = DEF_N_PORTS;
   localparam int ADDR_W     = DEF_ADDR_W;
   localparam int DATA_W     = DEF_DATA_W;
   localparam int LEN_W      = DEF_LEN_W;
   localparam int STRB_W     = DATA_W / 8;
   localparam int DEPTH      = 2 ** ADDR_W;
   localparam int WAIT_LIMIT = 100;   // Cycles a port may wait for ready

   logic                      clk;
   logic                      rst;
   logic [N_PORTS-1:0]        s_valid;
   logic [N_PORTS*ADDR_W-1:0] s_addr;
   logic [N_PORTS*DATA_W-1:0] s_wdata;
   logic [N_PORTS*STRB_W-1:0] s_wstrb;
   logic [N_PORTS*LEN_W-1:0]  s_len;
   logic [N_PORTS-1:0]        s_ready;
   logic [N_PORTS-1:0]        s_last;
   logic [DATA_W-1:0]         s_rdata;

   logic [DATA_W-1:0] shadow [DEPTH];   // Expected memory contents

   native_subsys_top #(
      .N_PORTS(N_PORTS),
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .LEN_W  (LEN_W)
   ) dut_i (
      .clk_i    (clk),
      .rst_i    (rst),
      .s_valid_i(s_valid),
      .s_addr_i (s_addr),
      .s_wdata_i(s_wdata),
      .s_wstrb_i(s_wstrb),
      .s_len_i  (s_len),
      .s_ready_o(s_ready),
      .s_last_o (s_last),
      .s_rdata_o(s_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ====================
   // Checks and models
   // ====================

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         abort_run($sformatf("** Error @ %0t ns: %s got %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_last(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("** Error @ %0t ns: %s last is %b, expected %b",
                             $time, what, got, exp));
      end
   endtask

   // Bytes without a strobe keep the old value
   task automatic shadow_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic [STRB_W-1:0] strb);
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            shadow[addr][8*b +: 8] = data[8*b +: 8];
         end
      end
   endtask

   function automatic logic [DATA_W-1:0] fill_word(input int addr);
      logic [31:0] h;
      h = (32'(addr) + 32'd1) * 32'h9E37_79B1;
      return DATA_W'(h);
   endfunction

   // ====================
   // Master driver
   // ====================

   task automatic drive_port(input int port, input logic valid, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                             input logic [LEN_W-1:0] len);
      s_valid[port]                 = valid;
      s_addr[port*ADDR_W +: ADDR_W] = addr;
      s_wdata[port*DATA_W +: DATA_W] = wdata;
      s_wstrb[port*STRB_W +: STRB_W] = strb;
      s_len[port*LEN_W +: LEN_W]    = len;
   endtask

   // Returns at the falling edge of a cycle where the port sees ready
   task automatic wait_ready(input int port, output int waited);
      burst_state_t st;
      waited = 0;
      @(negedge clk);
      while (!s_ready[port]) begin
         if (waited >= WAIT_LIMIT) begin
            st = dut_i.u_rd_engine.state_q;
            abort_run($sformatf("Timeout: port %0d saw no ready for %0d cycles, read engine in %s",
                                port, WAIT_LIMIT, st.name()));
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic write_burst(input int port, input logic [ADDR_W-1:0] addr,
                              input logic [LEN_W-1:0] len, input logic [DATA_W-1:0] data [$],
                              input logic [STRB_W-1:0] strb, output time t_first,
                              output time t_last);
      int waited;
      for (int beat = 0; beat <= int'(len); beat++) begin
         drive_port(port, 1'b1, addr, data[beat], strb, len);
         wait_ready(port, waited);
         if (beat == 0) begin
            t_first = $time;
         end
         t_last = $time;
         check_last(s_last[port], beat == int'(len),
                    $sformatf("write port %0d beat %0d", port, beat));
         shadow_write(addr + ADDR_W'(beat), data[beat], strb);
         @(posedge clk);
         #1;
      end
      drive_port(port, 1'b0, '0, '0, '0, '0);
   endtask

   task automatic read_burst(input int port, input logic [ADDR_W-1:0] addr,
                             input logic [LEN_W-1:0] len, output int first_wait);
      int waited;
      for (int beat = 0; beat <= int'(len); beat++) begin
         drive_port(port, 1'b1, addr, '0, '0, len);
         wait_ready(port, waited);
         if (beat == 0) begin
            first_wait = waited;
         end
         check_word(s_rdata, shadow[addr + ADDR_W'(beat)],
                    $sformatf("read port %0d addr %h", port, addr + ADDR_W'(beat)));
         check_last(s_last[port], beat == int'(len),
                    $sformatf("read port %0d beat %0d", port, beat));
         @(posedge clk);
         #1;
      end
      drive_port(port, 1'b0, '0, '0, '0, '0);
   endtask

   // ====================
   // Directed tests
   // ====================

   task automatic init_memory();
      logic [DATA_W-1:0] q [$];
      time t1;
      time t2;
      for (int base = 0; base < DEPTH; base += 16) begin
         q.delete();
         for (int i = 0; i < 16; i++) begin
            q.push_back(fill_word(base + i));
         end
         write_burst(0, ADDR_W'(base), LEN_W'(15), q, '1, t1, t2);
      end
   endtask

   task automatic single_beat_round_trip();
      time t1;
      time t2;
      int  waited;
      write_burst(1, 8'h21, 0, '{32'hCAFE_0001}, '1, t1, t2);
      read_burst(1, 8'h21, 0, waited);
      if (waited != 3) begin
         abort_run($sformatf("First read beat came %0d cycles after the request, not 3", waited));
      end
   endtask

   task automatic four_beat_bursts();
      time t1;
      time t2;
      int  waited;
      write_burst(2, 8'h40, 3, '{32'h0000_1111, 32'h2222_0000, 32'h3333_4444, 32'h5555_6666},
                  '1, t1, t2);
      read_burst(2, 8'h40, 3, waited);
   endtask

   task automatic partial_strobe_merge();
      time t1;
      time t2;
      int  waited;
      write_burst(0, 8'h60, 0, '{32'h1122_3344}, 4'b1111, t1, t2);
      write_burst(0, 8'h60, 0, '{32'hAABB_CCDD}, 4'b0101, t1, t2);
      read_burst(0, 8'h60, 0, waited);
   endtask

   task automatic write_contention();
      time t0_first;
      time t0_last;
      time t2_first;
      time t2_last;
      int  waited;
      fork
         write_burst(0, 8'h80, 1, '{32'hA0A0_0001, 32'hA0A0_0002}, '1, t0_first, t0_last);
         write_burst(2, 8'h90, 2, '{32'hB2B2_0001, 32'hB2B2_0002, 32'hB2B2_0003}, '1,
                     t2_first, t2_last);
      join
      if (t0_first <= t2_last) begin
         abort_run("Port 0 got ready before port 2 finished its write burst");
      end
      read_burst(1, 8'h80, 1, waited);
      read_burst(1, 8'h90, 2, waited);
   endtask

   task automatic parallel_write_read();
      logic [DATA_W-1:0] q [$];
      time t1;
      time t2;
      int  waited;
      for (int i = 0; i < 8; i++) begin
         q.push_back(32'hD00D_0000 + i);   // Write region stays clear of the read region
      end
      fork
         write_burst(0, 8'hA0, 7, q, '1, t1, t2);
         read_burst(1, 8'hC0, 5, waited);
      join
   endtask

   task automatic random_bursts();
      logic [DATA_W-1:0] q [$];
      int                port;
      int                len;
      int                addr;
      time               t1;
      time               t2;
      int                waited;
      for (int n = 0; n < 50; n++) begin
         port = $urandom_range(0, N_PORTS - 1);
         len  = $urandom_range(0, 2 ** LEN_W - 1);
         addr = $urandom_range(0, DEPTH - 1 - len);   // Bursts never wrap
         if ($urandom_range(0, 1) == 1) begin
            q.delete();
            for (int i = 0; i <= len; i++) begin
               q.push_back($urandom());
            end
            write_burst(port, ADDR_W'(addr), LEN_W'(len), q,
                        STRB_W'($urandom_range(1, 2 ** STRB_W - 1)), t1, t2);
         end else begin
            read_burst(port, ADDR_W'(addr), LEN_W'(len), waited);
         end
      end
   endtask

   initial begin
      void'($urandom(56));
      rst     = 1'b1;
      s_valid = '0;
      s_addr  = '0;
      s_wdata = '0;
      s_wstrb = '0;
      s_len   = '0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      @(posedge clk);
      #1;
      init_memory();
      single_beat_round_trip();
      four_beat_bursts();
      partial_strobe_merge();
      write_contention();
      parallel_write_read();
      random_bursts();
      if (dut_i.u_mux.u_assert.fail_cnt == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("%0d protocol assertions failed", dut_i.u_mux.u_assert.fail_cnt);
         $display("SIMULATION FAILED");
         $fatal(1, "Protocol assertions failed");
      end
   end

endmodule

//--- sim.f
native_pkg.sv
native_mem.sv
burst_write_engine.sv
burst_read_engine.sv
native_mux.sv
native_subsys_top.sv
native_assertions.sv
tb_native_subsys.sv

//--- Bender.yml
package:
  name: native_subsys

sources:
  - native_pkg.sv
  - native_mem.sv
  - burst_write_engine.sv
  - burst_read_engine.sv
  - native_mux.sv
  - native_subsys_top.sv
  - target: simulation
    files:
      - native_assertions.sv
      - tb_native_subsys.sv
